/* ddr_lite.f */
hdl/ddr_cmd_pkg.sv
hdl/ddr_bus_pkg.sv
hdl/ddr_bus_ctrl.sv
hdl/ddr_ctrl_fsm.sv
hdl/ddr_init_cfg.sv
hdl/ddr_dfi_layer.sv
hdl/ddr_lite_top.sv
tb/dfi_mem_model.sv
tb/tb_ddr_lite.sv

/* hdl/ddr_bus_ctrl.sv */
`timescale 1ns/1ps
module ddr_bus_ctrl #(
  parameter int ROW_BITS       = 13,
  parameter int COL_BITS       = 10,
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  logic                  run_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  ddr_bus_pkg::bus_req_t req_i,
  output logic                  op_valid_o,
  input  logic                  op_ready_i,
  output ddr_bus_pkg::mem_op_t  op_o,
  input  logic                  cpl_valid_i,
  output logic                  cpl_ready_o,
  input  ddr_bus_pkg::bus_rsp_t cpl_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output ddr_bus_pkg::bus_rsp_t rsp_o
);

  localparam int PW = $clog2(CMD_FIFO_DEPTH);
  localparam int CW = $clog2(CMD_FIFO_DEPTH + 1);
  localparam int CB = COL_BITS - 1;  // Word address carries column bits above bit 0

  ddr_bus_pkg::mem_op_t queue [CMD_FIFO_DEPTH];
  ddr_bus_pkg::mem_op_t split;
  ddr_bus_pkg::bus_rsp_t skid;
  logic [PW-1:0] wr_ptr, rd_ptr;
  logic [CW-1:0] count;
  logic push, pop, skid_valid;

  // Column low, then bank, then row
  always_comb begin
    split.we    = req_i.we;
    split.col   = {req_i.addr[CB-1:0], 1'b0};
    split.ba    = req_i.addr[CB+2:CB];
    split.row   = req_i.addr[CB+3+ROW_BITS-1:CB+3];
    split.wdata = req_i.wdata;
    split.mask  = ~req_i.strb;
    split.tag   = req_i.tag;
  end

  assign req_ready_o = run_i && (count != CW'(CMD_FIFO_DEPTH));
  assign push        = req_valid_i && req_ready_o;
  assign op_valid_o  = (count != '0);
  assign op_o        = queue[rd_ptr];
  assign pop         = op_valid_o && op_ready_i;

  always_ff @(posedge clock) begin
    if (push) queue[wr_ptr] <= split;
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      count <= count + CW'(push) - CW'(pop);
    end
  end

  // Output register plus one holding slot
  assign cpl_ready_o = !skid_valid;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      skid_valid  <= 1'b0;
    end else if (!rsp_valid_o || rsp_ready_i) begin
      rsp_valid_o <= skid_valid || cpl_valid_i;
      skid_valid  <= 1'b0;
    end else if (cpl_valid_i && cpl_ready_o) begin
      skid_valid <= 1'b1;  // Output stalled, park it
    end
  end

  always_ff @(posedge clock) begin
    if (!rsp_valid_o || rsp_ready_i) begin
      rsp_o <= skid_valid ? skid : cpl_i;
    end else if (cpl_valid_i && cpl_ready_o) begin
      skid <= cpl_i;
    end
  end

endmodule

/* hdl/ddr_bus_pkg.sv */
package ddr_bus_pkg;

  localparam int ROW_BITS  = 13;
  localparam int COL_BITS  = 10;
  localparam int WADR_BITS = 25;  // 32-bit word address
  localparam int TAG_BITS  = 4;

  typedef struct packed {
    logic                  we;
    logic [WADR_BITS-1:0]  addr;
    logic [31:0]           wdata;
    logic [3:0]            strb;
    logic [TAG_BITS-1:0]   tag;
  } bus_req_t;

  typedef struct packed {
    logic [31:0]           rdata;
    logic [TAG_BITS-1:0]   tag;
    logic                  was_write;
  } bus_rsp_t;

  // Request after the address split, handed from bus controller to FSM
  typedef struct packed {
    logic                  we;
    logic [2:0]            ba;
    logic [ROW_BITS-1:0]   row;
    logic [COL_BITS-1:0]   col;
    logic [31:0]           wdata;
    logic [3:0]            mask;
    logic [TAG_BITS-1:0]   tag;
  } mem_op_t;

endpackage

/* hdl/ddr_cmd_pkg.sv */
package ddr_cmd_pkg;

  // DDR3 command opcodes as carried on the DFI command bus
  typedef enum logic [2:0] {
    NOP  = 3'd0,
    MRS  = 3'd1,
    REF  = 3'd2,
    PRE  = 3'd3,
    ACT  = 3'd4,
    WR   = 3'd5,
    RD   = 3'd6,
    ZQCL = 3'd7
  } ddr_cmd_e;

  localparam int BANK_BITS = 3;
  localparam int ADDR_BITS = 13;
  localparam int DQ_BITS   = 32;  // Two 16-bit DQ beats
  localparam int DM_BITS   = 4;

  // One command per cycle, addr[10] selects all-bank precharge
  typedef struct packed {
    ddr_cmd_e               cmd;
    logic [BANK_BITS-1:0]   ba;
    logic [ADDR_BITS-1:0]   addr;
  } dfi_cmd_t;

  typedef struct packed {
    logic                 wren;
    logic [DM_BITS-1:0]   mask;  // High means byte is masked
    logic [DQ_BITS-1:0]   data;
  } dfi_wr_t;

  typedef struct packed {
    logic                 rvld;
    logic [DQ_BITS-1:0]   data;
  } dfi_rd_t;

endpackage

/* hdl/ddr_ctrl_fsm.sv */
`timescale 1ns/1ps
module ddr_ctrl_fsm #(
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10,
  parameter int T_RCD    = 3,
  parameter int T_RP     = 3,
  parameter int T_RFC    = 20
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  logic                  run_i,
  input  logic                  op_valid_i,
  output logic                  op_ready_o,
  input  ddr_bus_pkg::mem_op_t  op_i,
  input  logic                  ref_req_i,
  output logic                  ref_ack_o,
  input  logic                  rd_space_i,
  output ddr_cmd_pkg::dfi_cmd_t cmd_o,
  output ddr_cmd_pkg::dfi_wr_t  wr_o,
  output logic                  pend_push_o,
  output ddr_bus_pkg::bus_rsp_t pend_o
);

  typedef enum logic [2:0] {IDLE, PRECHARGE, ACTIVATE, ACCESS, REF_PRE, REF_WAIT} state_e;

  state_e state, state_nxt;
  logic [7:0] cnt, cnt_nxt;
  logic [7:0] bank_open;
  logic [ROW_BITS-1:0] open_row [8];
  logic is_open, is_hit, issue;

  assign is_open = bank_open[op_i.ba];
  assign is_hit  = is_open && (open_row[op_i.ba] == op_i.row);
  assign issue   = op_ready_o;  // Access goes out when the op is taken

  always_comb begin
    state_nxt   = state;
    cnt_nxt     = (cnt != '0) ? cnt - 1'b1 : cnt;
    cmd_o       = '{cmd: ddr_cmd_pkg::NOP, ba: op_i.ba, addr: '0};
    op_ready_o  = 1'b0;
    ref_ack_o   = 1'b0;
    case (state)
      IDLE: begin
        if (run_i && ref_req_i) begin
          cmd_o.cmd     = ddr_cmd_pkg::PRE;
          cmd_o.addr[10] = 1'b1;  // All banks
          cnt_nxt       = 8'(T_RP - 1);
          state_nxt     = REF_PRE;
        end else if (run_i && op_valid_i) begin
          if (is_hit) begin
            op_ready_o = rd_space_i;
          end else if (is_open) begin
            cmd_o.cmd = ddr_cmd_pkg::PRE;
            cnt_nxt   = 8'(T_RP - 1);
            state_nxt = PRECHARGE;
          end else begin
            cmd_o.cmd  = ddr_cmd_pkg::ACT;
            cmd_o.addr = op_i.row;
            cnt_nxt    = 8'(T_RCD - 1);
            state_nxt  = ACTIVATE;
          end
        end
      end
      PRECHARGE: if (cnt == '0) begin
        cmd_o.cmd  = ddr_cmd_pkg::ACT;
        cmd_o.addr = op_i.row;
        cnt_nxt    = 8'(T_RCD - 1);
        state_nxt  = ACTIVATE;
      end
      ACTIVATE: if (cnt == '0) state_nxt = ACCESS;
      ACCESS: begin
        op_ready_o = rd_space_i;  // Holds off while completions back up
        if (rd_space_i) state_nxt = IDLE;
      end
      REF_PRE: if (cnt == '0) begin
        cmd_o.cmd = ddr_cmd_pkg::REF;
        ref_ack_o = 1'b1;
        cnt_nxt   = 8'(T_RFC - 1);
        state_nxt = REF_WAIT;
      end
      REF_WAIT: if (cnt == '0) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
    if (issue) begin
      cmd_o.cmd  = op_i.we ? ddr_cmd_pkg::WR : ddr_cmd_pkg::RD;
      cmd_o.addr = {{(13 - COL_BITS){1'b0}}, op_i.col};
    end
  end

  // Write beat and completion entry travel with the access command
  assign wr_o        = '{wren: issue && op_i.we, mask: op_i.mask, data: op_i.wdata};
  assign pend_push_o = issue;
  assign pend_o      = '{rdata: '0, tag: op_i.tag, was_write: op_i.we};

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state     <= IDLE;
      cnt       <= '0;
      bank_open <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= cnt_nxt;
      if (cmd_o.cmd == ddr_cmd_pkg::PRE) begin
        if (cmd_o.addr[10]) bank_open <= '0;
        else bank_open[cmd_o.ba] <= 1'b0;
      end else if (cmd_o.cmd == ddr_cmd_pkg::ACT) begin
        bank_open[cmd_o.ba] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_o.cmd == ddr_cmd_pkg::ACT) open_row[cmd_o.ba] <= op_i.row;
  end

endmodule

/* hdl/ddr_dfi_layer.sv */
`timescale 1ns/1ps
module ddr_dfi_layer #(
  parameter int DEPTH = 8
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  ddr_cmd_pkg::dfi_cmd_t cmd_i,
  input  ddr_cmd_pkg::dfi_cmd_t cfg_cmd_i,
  input  logic                  cfg_active_i,
  input  ddr_cmd_pkg::dfi_wr_t  wr_i,
  input  logic                  pend_push_i,
  input  ddr_bus_pkg::bus_rsp_t pend_i,
  output logic                  rd_space_o,
  output ddr_cmd_pkg::dfi_cmd_t dfi_cmd_o,
  output ddr_cmd_pkg::dfi_wr_t  dfi_wr_o,
  input  ddr_cmd_pkg::dfi_rd_t  dfi_rd_i,
  output logic                  cpl_valid_o,
  input  logic                  cpl_ready_i,
  output ddr_bus_pkg::bus_rsp_t cpl_o
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  ddr_bus_pkg::bus_rsp_t pend_q [DEPTH];  // Tags in issue order
  logic [31:0] rdat_q [DEPTH];            // Read data in return order
  logic [PW-1:0] p_wr, p_rd, d_wr, d_rd;
  logic [CW-1:0] p_cnt, d_cnt;
  ddr_bus_pkg::bus_rsp_t head;
  logic pop;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      dfi_cmd_o <= '{cmd: ddr_cmd_pkg::NOP, ba: '0, addr: '0};
      dfi_wr_o  <= '0;
    end else begin
      dfi_cmd_o <= cfg_active_i ? cfg_cmd_i : cmd_i;
      dfi_wr_o  <= wr_i;
    end
  end

  assign head        = pend_q[p_rd];
  assign cpl_valid_o = (p_cnt != '0) && (head.was_write || d_cnt != '0);
  assign pop         = cpl_valid_o && cpl_ready_i;
  assign rd_space_o  = (p_cnt < CW'(DEPTH - 1));  // One slot kept for the access in flight

  always_comb begin
    cpl_o       = head;
    cpl_o.rdata = head.was_write ? '0 : rdat_q[d_rd];
  end

  always_ff @(posedge clock) begin
    if (pend_push_i) pend_q[p_wr] <= pend_i;
    if (dfi_rd_i.rvld) rdat_q[d_wr] <= dfi_rd_i.data;
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      p_wr  <= '0;
      p_rd  <= '0;
      d_wr  <= '0;
      d_rd  <= '0;
      p_cnt <= '0;
      d_cnt <= '0;
    end else begin
      if (pend_push_i) p_wr <= p_wr + 1'b1;
      if (pop) p_rd <= p_rd + 1'b1;
      if (dfi_rd_i.rvld) d_wr <= d_wr + 1'b1;
      if (pop && !head.was_write) d_rd <= d_rd + 1'b1;
      p_cnt <= p_cnt + CW'(pend_push_i) - CW'(pop);
      d_cnt <= d_cnt + CW'(dfi_rd_i.rvld) - CW'(pop && !head.was_write);
    end
  end

endmodule

/* hdl/ddr_init_cfg.sv */
`timescale 1ns/1ps
module ddr_init_cfg #(
  parameter int INIT_CYCLES = 50,
  parameter int T_MRD       = 4,
  parameter int REFI_CYCLES = 390
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  output logic                  dfi_rst_n_o,
  output logic                  dfi_cke_o,
  output ddr_cmd_pkg::dfi_cmd_t cfg_cmd_o,
  output logic                  cfg_active_o,
  output logic                  run_o,
  output logic                  ref_req_o,
  input  logic                  ref_ack_i
);

  typedef enum logic [1:0] {ST_RST, ST_CKE, ST_MRS, ST_RUN} state_e;

  localparam int CW = $clog2(INIT_CYCLES + REFI_CYCLES + T_MRD + 1);

  state_e state;
  logic [CW-1:0] cnt;
  logic [2:0] idx;
  ddr_cmd_pkg::dfi_cmd_t entry;

  // MR2, MR3, MR1, MR0 then ZQ calibration
  always_comb begin
    case (idx)
      3'd0:    entry = '{cmd: ddr_cmd_pkg::MRS, ba: 3'd2, addr: 13'h0008};  // CWL 6
      3'd1:    entry = '{cmd: ddr_cmd_pkg::MRS, ba: 3'd3, addr: 13'h0000};
      3'd2:    entry = '{cmd: ddr_cmd_pkg::MRS, ba: 3'd1, addr: 13'h0006};
      3'd3:    entry = '{cmd: ddr_cmd_pkg::MRS, ba: 3'd0, addr: 13'h0520};  // CL 6, DLL reset
      default: entry = '{cmd: ddr_cmd_pkg::ZQCL, ba: 3'd0, addr: 13'h0400};
    endcase
  end

  assign cfg_active_o = !run_o;
  assign cfg_cmd_o    = (state == ST_MRS && cnt == '0) ? entry
                        : '{cmd: ddr_cmd_pkg::NOP, ba: '0, addr: '0};

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state       <= ST_RST;
      cnt         <= CW'(INIT_CYCLES - 1);
      idx         <= '0;
      dfi_rst_n_o <= 1'b0;
      dfi_cke_o   <= 1'b0;
      run_o       <= 1'b0;
      ref_req_o   <= 1'b0;
    end else begin
      cnt <= cnt - 1'b1;
      case (state)
        ST_RST: if (cnt == '0) begin
          dfi_rst_n_o <= 1'b1;
          cnt         <= CW'(INIT_CYCLES - 1);
          state       <= ST_CKE;
        end
        ST_CKE: if (cnt == '0) begin
          dfi_cke_o <= 1'b1;
          cnt       <= CW'(T_MRD - 1);
          state     <= ST_MRS;
        end
        ST_MRS: if (cnt == '0) begin
          cnt <= CW'(T_MRD - 1);
          idx <= idx + 1'b1;
          if (idx == 3'd4) begin
            run_o <= 1'b1;
            cnt   <= CW'(REFI_CYCLES - 1);
            state <= ST_RUN;
          end
        end
        default: begin
          // Refresh interval timer, request held until taken
          if (cnt == '0) begin
            cnt       <= CW'(REFI_CYCLES - 1);
            ref_req_o <= 1'b1;
          end else if (ref_ack_i) begin
            ref_req_o <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

/* hdl/ddr_lite_top.sv */
`timescale 1ns/1ps
module ddr_lite_top #(
  parameter int ROW_BITS       = 13,
  parameter int COL_BITS       = 10,
  parameter int T_RCD          = 3,
  parameter int T_RP           = 3,
  parameter int T_RFC          = 20,
  parameter int T_MRD          = 4,
  parameter int REFI_CYCLES    = 390,
  parameter int INIT_CYCLES    = 50,
  parameter int CMD_FIFO_DEPTH = 4
) (
  input  logic                  clock,
  input  logic                  rst_n_i,
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  ddr_bus_pkg::bus_req_t req_i,
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output ddr_bus_pkg::bus_rsp_t rsp_o,
  output logic                  init_done_o,
  output logic                  dfi_rst_n_o,
  output logic                  dfi_cke_o,
  output ddr_cmd_pkg::dfi_cmd_t dfi_cmd_o,
  output ddr_cmd_pkg::dfi_wr_t  dfi_wr_o,
  input  ddr_cmd_pkg::dfi_rd_t  dfi_rd_i
);

  logic run, op_valid, op_ready, cpl_valid, cpl_ready;
  logic ref_req, ref_ack, rd_space, pend_push, cfg_active;
  ddr_bus_pkg::mem_op_t op;
  ddr_bus_pkg::bus_rsp_t cpl, pend;
  ddr_cmd_pkg::dfi_cmd_t fsm_cmd, cfg_cmd;
  ddr_cmd_pkg::dfi_wr_t fsm_wr;

  assign init_done_o = run;

  ddr_bus_ctrl #(.ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS), .CMD_FIFO_DEPTH(CMD_FIFO_DEPTH))
  u_bus (
    .clock(clock), .rst_n_i(rst_n_i), .run_i(run),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
    .op_valid_o(op_valid), .op_ready_i(op_ready), .op_o(op),
    .cpl_valid_i(cpl_valid), .cpl_ready_o(cpl_ready), .cpl_i(cpl),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o)
  );

  ddr_ctrl_fsm #(.ROW_BITS(ROW_BITS), .COL_BITS(COL_BITS),
                 .T_RCD(T_RCD), .T_RP(T_RP), .T_RFC(T_RFC))
  u_fsm (
    .clock(clock), .rst_n_i(rst_n_i), .run_i(run),
    .op_valid_i(op_valid), .op_ready_o(op_ready), .op_i(op),
    .ref_req_i(ref_req), .ref_ack_o(ref_ack), .rd_space_i(rd_space),
    .cmd_o(fsm_cmd), .wr_o(fsm_wr), .pend_push_o(pend_push), .pend_o(pend)
  );

  ddr_init_cfg #(.INIT_CYCLES(INIT_CYCLES), .T_MRD(T_MRD), .REFI_CYCLES(REFI_CYCLES))
  u_init (
    .clock(clock), .rst_n_i(rst_n_i),
    .dfi_rst_n_o(dfi_rst_n_o), .dfi_cke_o(dfi_cke_o),
    .cfg_cmd_o(cfg_cmd), .cfg_active_o(cfg_active), .run_o(run),
    .ref_req_o(ref_req), .ref_ack_i(ref_ack)
  );

  // Completion queue sized to twice the request queue
  ddr_dfi_layer #(.DEPTH(2 * CMD_FIFO_DEPTH)) u_dfi (
    .clock(clock), .rst_n_i(rst_n_i),
    .cmd_i(fsm_cmd), .cfg_cmd_i(cfg_cmd), .cfg_active_i(cfg_active), .wr_i(fsm_wr),
    .pend_push_i(pend_push), .pend_i(pend), .rd_space_o(rd_space),
    .dfi_cmd_o(dfi_cmd_o), .dfi_wr_o(dfi_wr_o), .dfi_rd_i(dfi_rd_i),
    .cpl_valid_o(cpl_valid), .cpl_ready_i(cpl_ready), .cpl_o(cpl)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the ddr_lite simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_ddr_lite \
  -f ddr_lite.f -o sim_ddr_lite

./obj_dir/sim_ddr_lite | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* tb/dfi_mem_model.sv */
`timescale 1ns/1ps
module dfi_mem_model #(
  parameter int REFI_CYCLES = 390,
  parameter int RD_LAT      = 5
) (
  input  logic                  clock,
  input  logic                  dfi_rst_n_i,
  input  logic                  dfi_cke_i,
  input  ddr_cmd_pkg::dfi_cmd_t dfi_cmd_i,
  input  ddr_cmd_pkg::dfi_wr_t  dfi_wr_i,
  output ddr_cmd_pkg::dfi_rd_t  dfi_rd_o
);

  logic [31:0] mem [logic [24:0]];  // Keyed by {row, bank, column word}
  logic [7:0] bank_open = '0;
  logic [12:0] row_q [8];
  int cyc = 0;
  int last_ref = 0;
  int act_cnt = 0;
  int ref_cnt = 0;
  int mrs_cnt = 0;
  int zq_cnt = 0;
  int cmd_err = 0;
  int ref_err = 0;
  int init_err = 0;
  logic [31:0] rd_data_q [$];
  int rd_due_q [$];
  ddr_cmd_pkg::dfi_rd_t rd_q = '0;
  logic [24:0] wa;
  logic [31:0] word;

  assign dfi_rd_o = rd_q;

  always @(posedge clock) begin
    cyc++;
    rd_q <= '0;
    if (rd_due_q.size() != 0 && rd_due_q[0] == cyc) begin
      rd_q <= '{rvld: 1'b1, data: rd_data_q.pop_front()};
      void'(rd_due_q.pop_front());
    end
    wa = {row_q[dfi_cmd_i.ba], dfi_cmd_i.ba, dfi_cmd_i.addr[9:1]};
    word = mem.exists(wa) ? mem[wa] : {wa[6:0], wa};  // Unwritten words read the fill
    case (dfi_cmd_i.cmd)
      ddr_cmd_pkg::MRS, ddr_cmd_pkg::ZQCL: begin
        if (!dfi_cke_i || !dfi_rst_n_i) begin
          cmd_err++;
          $display("Illegal command at %0t ns: mode register access with CKE low", $time);
        end
        if (dfi_cmd_i.cmd == ddr_cmd_pkg::MRS) mrs_cnt++;
        else zq_cnt++;
        last_ref = cyc;  // Refresh interval starts at the end of init
      end
      ddr_cmd_pkg::ACT: begin
        if (act_cnt == 0 && (mrs_cnt != 4 || zq_cnt != 1)) begin
          init_err++;
          $display("First ACT came after %0d MRS and %0d ZQCL commands", mrs_cnt, zq_cnt);
        end
        if (bank_open[dfi_cmd_i.ba]) begin
          cmd_err++;
          $display("Illegal command at %0t ns: ACT to open bank %0d", $time, dfi_cmd_i.ba);
        end
        bank_open[dfi_cmd_i.ba] = 1'b1;
        row_q[dfi_cmd_i.ba] = dfi_cmd_i.addr;
        act_cnt++;
      end
      ddr_cmd_pkg::PRE: begin
        if (dfi_cmd_i.addr[10]) bank_open = '0;
        else bank_open[dfi_cmd_i.ba] = 1'b0;
      end
      ddr_cmd_pkg::REF: begin
        if (bank_open != '0) begin
          ref_err++;
          $display("Illegal command at %0t ns: REF with banks %b open", $time, bank_open);
        end
        if (cyc - last_ref > REFI_CYCLES + 100) begin
          ref_err++;
          $display("Refresh gap of %0d cycles at %0t ns is too long", cyc - last_ref, $time);
        end
        last_ref = cyc;
        ref_cnt++;
      end
      ddr_cmd_pkg::WR: begin
        if (!bank_open[dfi_cmd_i.ba] || !dfi_wr_i.wren) begin
          cmd_err++;
          $display("Illegal command at %0t ns: WR to closed bank or without write beat", $time);
        end
        for (int b = 0; b < 4; b++) begin
          if (!dfi_wr_i.mask[b]) word[8*b +: 8] = dfi_wr_i.data[8*b +: 8];
        end
        mem[wa] = word;
      end
      ddr_cmd_pkg::RD: begin
        if (!bank_open[dfi_cmd_i.ba]) begin
          cmd_err++;
          $display("Illegal command at %0t ns: RD to closed bank %0d", $time, dfi_cmd_i.ba);
        end
        rd_data_q.push_back(word);
        rd_due_q.push_back(cyc + RD_LAT);
      end
      default: ;
    endcase
  end

endmodule

/* tb/tb_ddr_lite.sv */
`timescale 1ns/1ps
module tb_ddr_lite;

  localparam int NUM_REQ     = 400;
  localparam int INIT_CYCLES = 50;
  localparam int REFI_CYCLES = 390;
  localparam int SEED        = 18597;
  localparam int WD_CYCLES   = NUM_REQ * 200 + 20000;

  logic clock = 1'b0;
  logic rst_n_i;
  logic req_valid_i;
  logic req_ready_o;
  ddr_bus_pkg::bus_req_t req_i;
  logic rsp_valid_o;
  logic rsp_ready_i = 1'b0;
  ddr_bus_pkg::bus_rsp_t rsp_o;
  logic init_done_o, dfi_rst_n_o, dfi_cke_o;
  ddr_cmd_pkg::dfi_cmd_t dfi_cmd_o;
  ddr_cmd_pkg::dfi_wr_t dfi_wr_o;
  ddr_cmd_pkg::dfi_rd_t dfi_rd_i;

  logic [31:0] ref_mem [logic [24:0]];  // Reference contents per word address
  ddr_bus_pkg::bus_rsp_t exp_q [$];
  ddr_bus_pkg::bus_req_t iss_q [$];     // Accepted requests in issue order
  logic [7:0] tb_open = '0;
  logic [12:0] tb_row [8];
  ddr_bus_pkg::bus_rsp_t held_rsp;
  logic stalled = 1'b0;
  int rsp_cnt = 0;
  int exp_act = 0;
  int rst_wait = 0;
  int cke_wait = 0;
  int startup_err = 0;
  int data_err = 0;
  int row_err = 0;
  int bp_err = 0;
  int refresh_err = 0;
  int tests_failed = 0;
  int total_err = 0;

  ddr_lite_top #(.INIT_CYCLES(INIT_CYCLES), .REFI_CYCLES(REFI_CYCLES)) UUT (
    .clock(clock), .rst_n_i(rst_n_i),
    .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
    .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
    .init_done_o(init_done_o), .dfi_rst_n_o(dfi_rst_n_o), .dfi_cke_o(dfi_cke_o),
    .dfi_cmd_o(dfi_cmd_o), .dfi_wr_o(dfi_wr_o), .dfi_rd_i(dfi_rd_i)
  );

  dfi_mem_model #(.REFI_CYCLES(REFI_CYCLES)) MEM (
    .clock(clock), .dfi_rst_n_i(dfi_rst_n_o), .dfi_cke_i(dfi_cke_o),
    .dfi_cmd_i(dfi_cmd_o), .dfi_wr_i(dfi_wr_o), .dfi_rd_o(dfi_rd_i)
  );

  always #10 clock = ~clock;

  // Small bank and row pool so hits and misses both show up
  function automatic ddr_bus_pkg::bus_req_t rand_req(input int n);
    ddr_bus_pkg::bus_req_t r;
    r.we    = 1'($urandom % 2);
    r.addr  = {13'(($urandom % 3) * 2900 + 7), 3'($urandom % 4), 9'($urandom % 16)};
    r.wdata = $urandom;
    r.strb  = 4'($urandom % 16);
    r.tag   = 4'(n);
    return r;
  endfunction

  task automatic record_accept(input ddr_bus_pkg::bus_req_t r);
    logic [31:0] cur;
    cur = ref_mem.exists(r.addr) ? ref_mem[r.addr] : {r.addr[6:0], r.addr};
    if (r.we) begin
      for (int b = 0; b < 4; b++) begin
        if (r.strb[b]) cur[8*b +: 8] = r.wdata[8*b +: 8];
      end
      ref_mem[r.addr] = cur;
    end
    exp_q.push_back('{rdata: r.we ? 32'd0 : cur, tag: r.tag, was_write: r.we});
    iss_q.push_back(r);
  endtask

  task automatic report_test(input string name, input int errs);
    $display("Test %-10s %s, %0d errors", name, (errs == 0) ? "passed" : "failed", errs);
    if (errs != 0) tests_failed++;
    total_err += errs;
  endtask

  always @(posedge clock) begin
    if (rst_n_i && !init_done_o) begin
      if (req_ready_o) begin
        startup_err++;
        $display("req_ready_o high before init_done_o at %0t ns", $time);
      end
      if (dfi_cke_o && !dfi_rst_n_o) begin
        startup_err++;
        $display("dfi_cke_o high while memory still in reset at %0t ns", $time);
      end
      if (!dfi_rst_n_o) rst_wait++;
      if (dfi_rst_n_o && !dfi_cke_o) cke_wait++;
    end
  end

  // Row policy from the request stream, REF closes every bank
  always @(posedge clock) begin
    ddr_bus_pkg::bus_req_t q;
    logic [2:0] ba;
    logic [12:0] row;
    if (dfi_cmd_o.cmd == ddr_cmd_pkg::REF) tb_open = '0;
    if (dfi_cmd_o.cmd == ddr_cmd_pkg::WR || dfi_cmd_o.cmd == ddr_cmd_pkg::RD) begin
      if (iss_q.size() == 0) begin
        row_err++;
        $display("Access command at %0t ns with no request waiting", $time);
      end else begin
        q = iss_q.pop_front();
        ba = q.addr[11:9];
        row = q.addr[24:12];
        if (dfi_cmd_o.ba != ba || dfi_cmd_o.addr[9:0] != {q.addr[8:0], 1'b0}
            || (dfi_cmd_o.cmd == ddr_cmd_pkg::WR) != q.we
            || (q.we && (dfi_wr_o.data != q.wdata || dfi_wr_o.mask != ~q.strb))) begin
          data_err++;
          $display("Mismatch at %0t ns: access for tag %0d has wrong bank, column or data",
                   $time, q.tag);
        end
        if (MEM.row_q[ba] != row) begin
          row_err++;
          $display("Mismatch at %0t ns: access went to row %0d of bank %0d, not row %0d",
                   $time, MEM.row_q[ba], ba, row);
        end
        if (!(tb_open[ba] && tb_row[ba] == row)) exp_act++;
        tb_open[ba] = 1'b1;
        tb_row[ba] = row;
      end
    end
  end

  always @(posedge clock) begin
    ddr_bus_pkg::bus_rsp_t e;
    if (stalled && (!rsp_valid_o || rsp_o != held_rsp)) begin
      bp_err++;
      $display("Mismatch at %0t ns: response changed while stalled", $time);
    end
    stalled = rsp_valid_o && !rsp_ready_i;
    held_rsp = rsp_o;
    if (rsp_valid_o && rsp_ready_i) begin
      rsp_cnt++;
      if (exp_q.size() == 0) begin
        bp_err++;
        $display("Extra response with tag %0d and no request outstanding", rsp_o.tag);
      end else begin
        e = exp_q.pop_front();
        if (rsp_o.tag != e.tag || rsp_o.was_write != e.was_write
            || (!e.was_write && rsp_o.rdata != e.rdata)) begin
          data_err++;
          $display("Mismatch at %0t ns: tag %0d wr %0b data %h, expected tag %0d wr %0b data %h",
                   $time, rsp_o.tag, rsp_o.was_write, rsp_o.rdata, e.tag, e.was_write, e.rdata);
        end
      end
    end
    // Stalls come in phases to fill the completion FIFO
    rsp_ready_i <= ($urandom % 8) < ((rsp_cnt % 100 >= 60) ? 1 : 6);
  end

  initial begin
    repeat (WD_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles with %0d responses", WD_CYCLES, rsp_cnt);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    ddr_bus_pkg::bus_req_t r;
    void'($urandom(SEED));
    rst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    repeat (2) @(posedge clock);
    rst_n_i <= 1'b1;
    while (!init_done_o) @(posedge clock);
    repeat (2) @(posedge clock);
    if (rst_wait != INIT_CYCLES || cke_wait != INIT_CYCLES) begin
      startup_err++;
      $display("Mismatch at %0t ns: reset hold %0d and CKE delay %0d, expected %0d",
               $time, rst_wait, cke_wait, INIT_CYCLES);
    end
    if (MEM.mrs_cnt != 4 || MEM.zq_cnt != 1) begin
      startup_err++;
      $display("Mismatch at %0t ns: %0d MRS and %0d ZQCL during init, expected 4 and 1",
               $time, MEM.mrs_cnt, MEM.zq_cnt);
    end
    report_test("startup", startup_err);

    for (int i = 0; i < NUM_REQ; i++) begin
      r = rand_req(i);
      if ($urandom % 8 == 0) begin
        req_valid_i <= 1'b0;
        @(posedge clock);
      end
      req_valid_i <= 1'b1;
      req_i <= r;
      @(posedge clock);
      while (!req_ready_o) @(posedge clock);
      record_accept(r);
    end
    req_valid_i <= 1'b0;
    while (rsp_cnt < NUM_REQ) @(posedge clock);
    report_test("data", data_err);
    repeat (20) @(negedge clock);  // Let any stray response show up

    if (MEM.act_cnt != exp_act) begin
      row_err++;
      $display("Mismatch at %0t ns: %0d ACT commands, expected %0d",
               $time, MEM.act_cnt, exp_act);
    end
    report_test("row", row_err + MEM.cmd_err + MEM.init_err);
    if (MEM.ref_cnt == 0) begin
      refresh_err++;
      $display("No REF command was issued during the run");
    end
    if (MEM.cyc - MEM.last_ref > REFI_CYCLES + 100) begin
      refresh_err++;
      $display("No REF command in the last %0d cycles of the run", MEM.cyc - MEM.last_ref);
    end
    report_test("refresh", MEM.ref_err + refresh_err);
    if (rsp_cnt != NUM_REQ || exp_q.size() != 0) begin
      bp_err++;
      $display("Mismatch at %0t ns: %0d responses seen for %0d requests",
               $time, rsp_cnt, NUM_REQ);
    end
    report_test("backpress", bp_err);

    $display("Summary: 5 tests, %0d failed, %0d errors", tests_failed, total_err);
    if (total_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
